//--- Bender.yml
package:
  name: oflow_score_calc

sources:
  # packages first, compile order matters
  - files:
      - logic/oflow_core_pkg.sv
      - logic/oflow_score_pkg.sv
  # score stage RTL
  - files:
      - logic/oflow_score_calc_similarity_metric_fsm.sv
      - logic/oflow_similarity_metric.sv
      - logic/oflow_score_select.sv
      - logic/oflow_score_calc.sv
  # testbench
  - target: test
    files:
      - tb/oflow_score_calc_tb.sv

//--- compile.f
logic/oflow_core_pkg.sv
logic/oflow_score_pkg.sv
logic/oflow_score_calc_similarity_metric_fsm.sv
logic/oflow_similarity_metric.sv
logic/oflow_score_select.sv
logic/oflow_score_calc.sv
tb/oflow_score_calc_tb.sv

//--- logic/oflow_core_pkg.sv
/*
 * object-level types for the optical-flow core
 * ids, bounding-box fields and the feature struct passed between stages
 */

`default_nettype none

package oflow_core_pkg;

	// --------------------------------------------------
	// object ids
	// --------------------------------------------------

	// id width, zero marks an empty slot
	localparam int ID_LEN = 8;

	typedef logic [ID_LEN-1:0] id_t;

	// --------------------------------------------------
	// bounding-box features
	// --------------------------------------------------

	// one box field, position or size
	localparam int COORD_LEN = 10;

	typedef logic [COORD_LEN-1:0] coord_t;

	// box of one object, x in the top bits
	typedef struct packed {
		coord_t x;
		coord_t y;
		// size fields
		coord_t w;
		coord_t h;
	} obj_feature_t;

endpackage

`default_nettype wire

//--- logic/oflow_score_calc.sv
/*
 * score stage top, one new object against two tracked candidates
 * controller, two parallel engines and the selector; fixed six-cycle latency
 */

`timescale 1ns/1ns
`default_nettype none

module oflow_score_calc
	import oflow_core_pkg::*;
	import oflow_score_pkg::*;
#(
	// size field weight, passed to both engines
	parameter int SIZE_WEIGHT_SHIFT = 1
) (
	input logic clk,
	input logic reset_N,

	input logic start_score_calc,
	// inputs held stable until the engines latch them
	input obj_feature_t new_obj,
	input obj_feature_t cand_0,
	input id_t id_0,
	input obj_feature_t cand_1,
	input id_t id_1,

	output logic done_score_calc,
	output sim_result_t result
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------

	logic start_similarity_metric_0;
	logic start_similarity_metric_1;
	logic done_0;
	logic done_1;
	sim_result_t result_0;
	sim_result_t result_1;

	// --------------------------------------------------
	// controller
	// --------------------------------------------------
	oflow_score_calc_similarity_metric_fsm u_fsm (
		.clk (clk),
		.reset_N (reset_N),
		.start_score_calc (start_score_calc),
		.id_1 (id_1),
		// slot 0 always runs, its done closes the round
		.done_similarity_metric (done_0),
		.start_similarity_metric_0 (start_similarity_metric_0),
		.start_similarity_metric_1 (start_similarity_metric_1)
	);

	// --------------------------------------------------
	// engines
	// --------------------------------------------------
	oflow_similarity_metric #(
		.SIZE_WEIGHT_SHIFT (SIZE_WEIGHT_SHIFT)
	) u_sim_0 (
		.clk (clk),
		.reset_N (reset_N),
		.start (start_similarity_metric_0),
		.new_obj (new_obj),
		.cand (cand_0),
		.cand_id (id_0),
		.done (done_0),
		.result (result_0)
	);

	oflow_similarity_metric #(
		.SIZE_WEIGHT_SHIFT (SIZE_WEIGHT_SHIFT)
	) u_sim_1 (
		.clk (clk),
		.reset_N (reset_N),
		.start (start_similarity_metric_1),
		.new_obj (new_obj),
		.cand (cand_1),
		.cand_id (id_1),
		.done (done_1),
		.result (result_1)
	);

	// --------------------------------------------------
	// best match
	// --------------------------------------------------
	oflow_score_select u_select (
		.clk (clk),
		.reset_N (reset_N),
		.done_0 (done_0),
		.result_0 (result_0),
		.done_1 (done_1),
		.result_1 (result_1),
		.done_score_calc (done_score_calc),
		.result (result)
	);

endmodule

`default_nettype wire

//--- logic/oflow_score_calc_similarity_metric_fsm.sv
/*
 * score stage controller
 * turns start_score_calc into one start pulse per engine and then waits for done
 * slot 1 engine only fires for a nonzero id_1
 */

`timescale 1ns/1ns
`default_nettype none

module oflow_score_calc_similarity_metric_fsm
	import oflow_core_pkg::*;
(
	input logic clk,
	input logic reset_N,

	// from registration
	input logic start_score_calc,
	// slot 1 id of zero means empty
	input id_t id_1,

	// engine handshake
	input logic done_similarity_metric,
	output logic start_similarity_metric_0,
	output logic start_similarity_metric_1
);

	// --------------------------------------------------
	// state and flags
	// --------------------------------------------------

	typedef enum logic [1:0] {
		idle_st,
		similarity_metric_st,
		wait_st
	} sm_state_t;

	sm_state_t current_state;
	sm_state_t next_state;

	// one start per visit to similarity_metric_st
	logic flg_start_similarity_metric;

	// --------------------------------------------------
	// state register
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			current_state <= idle_st;
		end else begin
			current_state <= next_state;
		end
	end

	// --------------------------------------------------
	// start flag
	// --------------------------------------------------
	// set on entry to similarity_metric_st and cleared the cycle after
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			flg_start_similarity_metric <= 1'b0;
		end else begin
			flg_start_similarity_metric <= (current_state == idle_st) &&
				(next_state == similarity_metric_st);
		end
	end

	// --------------------------------------------------
	// next state and outputs
	// --------------------------------------------------
	always_comb begin
		next_state = current_state;
		start_similarity_metric_0 = 1'b0;
		start_similarity_metric_1 = 1'b0;

		case (current_state)
			idle_st: begin
				// pulses outside idle are dropped
				if (start_score_calc) begin
					next_state = similarity_metric_st;
				end
			end

			similarity_metric_st: begin
				if (flg_start_similarity_metric) begin
					start_similarity_metric_0 = 1'b1;
					// empty slot 1 stays quiet
					start_similarity_metric_1 = |id_1;
				end
				next_state = wait_st;
			end

			wait_st: begin
				// single round then back to idle
				if (done_similarity_metric) begin
					next_state = idle_st;
				end
			end

			default: begin
				next_state = idle_st;
			end
		endcase
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// engines fired only in the cycle after an accepted start_score_calc
	a_start_after_accept: assert property (@(posedge clk) disable iff (!reset_N)
		(start_similarity_metric_0 || start_similarity_metric_1) |->
		$past((current_state == idle_st) && start_score_calc));

	// engine done only while waiting for it
	a_done_in_wait_st: assert property (@(posedge clk) disable iff (!reset_N)
		done_similarity_metric |-> (current_state == wait_st));

endmodule

`default_nettype wire

//--- logic/oflow_score_pkg.sv
/*
 * score types for the similarity stage
 * a score is a distance, lower means a closer match
 */

`default_nettype none

package oflow_score_pkg;

	// --------------------------------------------------
	// score width and limit
	// --------------------------------------------------

	localparam int SCORE_LEN = 12;

	typedef logic [SCORE_LEN-1:0] score_t;

	// saturation value, all ones
	localparam score_t SCORE_MAX = '1;

	// --------------------------------------------------
	// engine result
	// --------------------------------------------------

	// candidate id with its distance to the new object
	typedef struct packed {
		oflow_core_pkg::id_t id;
		score_t score;
	} sim_result_t;

endpackage

`default_nettype wire

//--- logic/oflow_score_select.sv
/*
 * picks the lower-distance candidate of the two engines
 * slot 1 only counts when its engine reported done, ties go to slot 0
 */

`timescale 1ns/1ns
`default_nettype none

module oflow_score_select
	import oflow_score_pkg::*;
(
	input logic clk,
	input logic reset_N,

	// slot 0 engine, always runs
	input logic done_0,
	input sim_result_t result_0,

	// slot 1 engine, silent when slot empty
	input logic done_1,
	input sim_result_t result_1,

	output logic done_score_calc,
	output sim_result_t result
);

	// --------------------------------------------------
	// choice
	// --------------------------------------------------

	logic take_1;
	sim_result_t best;

	// strictly lower only, so a tie keeps slot 0
	always_comb begin
		take_1 = done_1 && (result_1.score < result_0.score);
		best = take_1 ? result_1 : result_0;
	end

	// --------------------------------------------------
	// output registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			done_score_calc <= 1'b0;
			result <= '0;
		end else begin
			// one-cycle pulse per round
			done_score_calc <= done_0;
			if (done_0) begin
				result <= best;
			end
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// both engines start together, so slot 1 never finishes alone
	a_done_1_with_done_0: assert property (@(posedge clk) disable iff (!reset_N)
		done_1 |-> done_0);

endmodule

`default_nettype wire

//--- logic/oflow_similarity_metric.sv
/*
 * similarity engine, weighted absolute-difference distance of two boxes
 * operands latched on start, one field added per cycle, done four cycles later
 */

`timescale 1ns/1ns
`default_nettype none

module oflow_similarity_metric
	import oflow_core_pkg::*;
	import oflow_score_pkg::*;
#(
	// weight of the size fields, legal 0 to 2
	parameter int SIZE_WEIGHT_SHIFT = 1
) (
	input logic clk,
	input logic reset_N,

	input logic start,
	input obj_feature_t new_obj,
	input obj_feature_t cand,
	input id_t cand_id,

	output logic done,
	output sim_result_t result
);

	// --------------------------------------------------
	// widths and signals
	// --------------------------------------------------

	// four terms of at most (2^COORD_LEN - 1) << shift, no overflow
	localparam int ACC_LEN = COORD_LEN + SIZE_WEIGHT_SHIFT + 2;

	typedef logic [ACC_LEN-1:0] acc_t;

	// latched operands
	obj_feature_t new_obj_q;
	obj_feature_t cand_q;
	id_t cand_id_q;

	// control
	logic busy;
	logic [1:0] field_cnt;

	acc_t acc;
	acc_t term;
	acc_t acc_next;
	score_t score_sat;

	function automatic coord_t abs_diff(input coord_t a, input coord_t b);
		coord_t d;
		d = (a >= b) ? (a - b) : (b - a);
		return d;
	endfunction

	// --------------------------------------------------
	// field term and running sum
	// --------------------------------------------------
	always_comb begin
		case (field_cnt)
			2'd0: term = acc_t'(abs_diff(new_obj_q.x, cand_q.x));
			2'd1: term = acc_t'(abs_diff(new_obj_q.y, cand_q.y));
			// size fields weighted
			2'd2: term = acc_t'(abs_diff(new_obj_q.w, cand_q.w)) << SIZE_WEIGHT_SHIFT;
			default: term = acc_t'(abs_diff(new_obj_q.h, cand_q.h)) << SIZE_WEIGHT_SHIFT;
		endcase
		acc_next = acc + term;
		// clip to the score width
		score_sat = (acc_next > acc_t'(SCORE_MAX)) ? SCORE_MAX : score_t'(acc_next);
	end

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			field_cnt <= 2'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				field_cnt <= 2'd0;
			end else if (busy) begin
				field_cnt <= field_cnt + 2'd1;
				// h is the last field
				if (field_cnt == 2'd3) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (start) begin
			new_obj_q <= new_obj;
			cand_q <= cand;
			cand_id_q <= cand_id;
			acc <= '0;
		end else if (busy) begin
			acc <= acc_next;
			// result holds until the next round ends
			if (field_cnt == 2'd3) begin
				result <= '{id: cand_id_q, score: score_sat};
			end
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// controller must not restart a running engine
	a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_N)
		start |-> !busy);

endmodule

`default_nettype wire

//--- tb/oflow_score_calc_tb.sv
/*
 * self-checking testbench for the score stage top
 * hand-worked table rows, then seeded random rows, then a start while busy
 */

`timescale 1ns/1ns
`default_nettype none

module oflow_score_calc_tb
	import oflow_core_pkg::*;
	import oflow_score_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int WEIGHT_SHIFT = 1;
	localparam int NUM_TABLE = 8;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_ROWS = NUM_TABLE + NUM_RANDOM;
	// all rows plus the busy-start round
	localparam int WATCHDOG_ROWS = NUM_ROWS + 1;
	// edges from the sampled start to done_score_calc
	localparam int LATENCY = 6;

	logic clk;
	logic reset_N;
	logic start_score_calc;
	obj_feature_t new_obj;
	obj_feature_t cand_0;
	obj_feature_t cand_1;
	id_t id_0;
	id_t id_1;
	logic done_score_calc;
	sim_result_t result;

	integer seed;

	// stimulus / expected table
	string row_name [NUM_ROWS];
	obj_feature_t row_new [NUM_ROWS];
	obj_feature_t row_c0 [NUM_ROWS];
	obj_feature_t row_c1 [NUM_ROWS];
	id_t row_id0 [NUM_ROWS];
	id_t row_id1 [NUM_ROWS];
	sim_result_t row_exp [NUM_ROWS];

	oflow_score_calc #(
		.SIZE_WEIGHT_SHIFT (WEIGHT_SHIFT)
	) dut (
		.clk (clk),
		.reset_N (reset_N),
		.start_score_calc (start_score_calc),
		.new_obj (new_obj),
		.cand_0 (cand_0),
		.id_0 (id_0),
		.cand_1 (cand_1),
		.id_1 (id_1),
		.done_score_calc (done_score_calc),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------------------------------------
	// reporting
	// --------------------------------------------------
	task automatic stop_on_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("** Error: test %s, %s expected 0x%0h actual 0x%0h",
				name, what, expected, actual);
			stop_on_failure();
		end
	endtask

	// --------------------------------------------------
	// expected values from the scoring rule
	// --------------------------------------------------
	function automatic obj_feature_t box(input int x, input int y, input int w, input int h);
		obj_feature_t b;
		b.x = coord_t'(x);
		b.y = coord_t'(y);
		b.w = coord_t'(w);
		b.h = coord_t'(h);
		return b;
	endfunction

	function automatic int field_gap(input coord_t a, input coord_t b);
		return (a > b) ? (int'(a) - int'(b)) : (int'(b) - int'(a));
	endfunction

	// position gaps plus weighted size gaps, clipped at SCORE_MAX
	function automatic int box_distance(input obj_feature_t a, input obj_feature_t b);
		int d;
		d = field_gap(a.x, b.x) + field_gap(a.y, b.y) +
			((field_gap(a.w, b.w) + field_gap(a.h, b.h)) << WEIGHT_SHIFT);
		if (d > int'(SCORE_MAX))
			d = int'(SCORE_MAX);
		return d;
	endfunction

	// slot 1 wins only when present and strictly closer
	function automatic sim_result_t expected_match(input obj_feature_t n,
		input obj_feature_t c0, input id_t i0, input obj_feature_t c1, input id_t i1);
		int s0;
		int s1;
		sim_result_t r;
		s0 = box_distance(n, c0);
		s1 = box_distance(n, c1);
		if ((i1 != '0) && (s1 < s0)) begin
			r.id = i1;
			r.score = score_t'(s1);
		end else begin
			r.id = i0;
			r.score = score_t'(s0);
		end
		return r;
	endfunction

	// --------------------------------------------------
	// table setup
	// --------------------------------------------------
	task automatic set_row(input int idx, input string name, input obj_feature_t n,
		input obj_feature_t c0, input id_t i0, input obj_feature_t c1, input id_t i1,
		input id_t exp_id, input int exp_score);
		row_name[idx] = name;
		row_new[idx] = n;
		row_c0[idx] = c0;
		row_id0[idx] = i0;
		row_c1[idx] = c1;
		row_id1[idx] = i1;
		row_exp[idx].id = exp_id;
		row_exp[idx].score = score_t'(exp_score);
	endtask

	// scores worked out by hand with size weight 2
	task automatic fill_table();
		set_row(0, "single_basic", box(100, 200, 30, 40), box(110, 195, 33, 38), 8'h11,
			box(0, 0, 0, 0), 8'h00, 8'h11, 25);
		set_row(1, "single_zero", box(50, 60, 20, 20), box(50, 60, 20, 20), 8'h05,
			box(0, 0, 0, 0), 8'h00, 8'h05, 0);
		set_row(2, "best_slot1", box(300, 300, 50, 50), box(320, 310, 50, 50), 8'h21,
			box(302, 301, 51, 50), 8'h22, 8'h22, 5);
		set_row(3, "best_slot0", box(300, 300, 50, 50), box(301, 299, 50, 50), 8'h31,
			box(400, 300, 50, 60), 8'h32, 8'h31, 2);
		set_row(4, "tie_slot0", box(500, 500, 40, 40), box(510, 500, 40, 40), 8'h41,
			box(500, 500, 45, 40), 8'h42, 8'h41, 10);
		// slot 1 would be a perfect match but is empty
		set_row(5, "empty_slot1", box(200, 100, 60, 70), box(210, 120, 64, 70), 8'h51,
			box(200, 100, 60, 70), 8'h00, 8'h51, 38);
		set_row(6, "saturate", box(0, 0, 0, 0), box(1023, 1023, 1023, 1023), 8'h61,
			box(0, 0, 0, 0), 8'h00, 8'h61, 4095);
		set_row(7, "saturate_vs_large", box(0, 0, 0, 0), box(1023, 1023, 1023, 1023), 8'h63,
			box(1023, 1023, 0, 0), 8'h62, 8'h62, 2046);
	endtask

	function automatic obj_feature_t random_box();
		return box($random(seed), $random(seed), $random(seed), $random(seed));
	endfunction

	// small offsets keep scores away from saturation
	function automatic obj_feature_t near_box(input obj_feature_t n);
		return box(n.x + $random(seed) % 32, n.y + $random(seed) % 32,
			n.w + $random(seed) % 16, n.h + $random(seed) % 16);
	endfunction

	task automatic add_random_rows();
		obj_feature_t n;
		obj_feature_t c0;
		obj_feature_t c1;
		id_t i0;
		id_t i1;
		for (int k = 0; k < NUM_RANDOM; k++) begin
			n = random_box();
			if (k % 2 == 0) begin
				c0 = random_box();
				c1 = random_box();
			end else begin
				c0 = near_box(n);
				c1 = near_box(n);
			end
			// forced tie now and then
			if (k % 8 == 5)
				c1 = c0;
			i0 = id_t'($random(seed)) | 8'h01;
			i1 = (k % 4 == 3) ? id_t'(0) : (id_t'($random(seed)) | 8'h80);
			set_row(NUM_TABLE + k, $sformatf("random_%0d", k), n, c0, i0, c1, i1,
				8'h00, 0);
			row_exp[NUM_TABLE + k] = expected_match(n, c0, i0, c1, i1);
		end
	endtask

	// --------------------------------------------------
	// row execution
	// --------------------------------------------------
	task automatic drive_row(input int idx);
		new_obj = row_new[idx];
		cand_0 = row_c0[idx];
		id_0 = row_id0[idx];
		cand_1 = row_c1[idx];
		id_1 = row_id1[idx];
	endtask

	// called just after a drive point, returns just after the done edge
	task automatic apply_row(input int idx);
		int edges;
		bit seen;
		drive_row(idx);
		start_score_calc = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY start_score_calc = 1'b0;
		edges = 0;
		seen = 1'b0;
		while (!seen && edges < LATENCY + 4) begin
			@(posedge clk);
			#DRIVE_DELAY;
			edges++;
			seen = done_score_calc;
		end
		assert (seen) else begin
			$display("test %s never raised done_score_calc", row_name[idx]);
			stop_on_failure();
		end
		check_value(row_name[idx], "latency", LATENCY, edges);
		check_value(row_name[idx], "id", row_exp[idx].id, result.id);
		check_value(row_name[idx], "score", row_exp[idx].score, result.score);
	endtask

	// second start two cycles into a round, with other operands, is dropped
	task automatic busy_start_check(input int idx);
		int pulses;
		int first_edge;
		sim_result_t seen_result;
		pulses = 0;
		first_edge = 0;
		seen_result = '0;
		drive_row(idx);
		start_score_calc = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY start_score_calc = 1'b0;
		for (int e = 1; e <= LATENCY + 6; e++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (done_score_calc) begin
				pulses++;
				if (pulses == 1) begin
					first_edge = e;
					seen_result = result;
				end
			end
			start_score_calc = (e == 1);
			if (e == 1)
				new_obj = box(900, 900, 900, 900);
		end
		check_value("busy_start", "done pulses", 1, pulses);
		check_value("busy_start", "latency", LATENCY, first_edge);
		check_value("busy_start", "id", row_exp[idx].id, seen_result.id);
		check_value("busy_start", "score", row_exp[idx].score, seen_result.score);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		seed = 32'h89bc_d72b;
		reset_N = 1'b0;
		start_score_calc = 1'b0;
		new_obj = '0;
		cand_0 = '0;
		cand_1 = '0;
		id_0 = '0;
		id_1 = '0;
		fill_table();
		add_random_rows();

		repeat (8) @(posedge clk);
		#DRIVE_DELAY reset_N = 1'b1;

		// idle outputs before the first start
		repeat (2) begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_value("reset_state", "done_score_calc", 0, done_score_calc);
			check_value("reset_state", "result", 0, result);
		end

		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(r);
		busy_start_check(0);

		$display("TESTBENCH PASSED");
		$finish;
	end

	// watchdog, budget of ten cycles per round plus reset
	initial begin
		#(CLK_PERIOD * (WATCHDOG_ROWS * 10 + 20));
		$display("timeout, the run took longer than the watchdog allows");
		stop_on_failure();
	end

endmodule

`default_nettype wire
